// ==== design/fifo_bank_pkg.sv ====
package fifo_bank_pkg;

  // operation sent to one lane for a single cycle
  // encoding is {write, read}, so a rising pair maps straight onto it
  typedef enum logic [1:0]
  {
    op_idle  = 2'b00, // nothing to do
    op_read  = 2'b01, // pop oldest word
    op_write = 2'b10, // push din
    op_both  = 2'b11  // push and pop together
  } lane_op_t;

  // default sizing of the bank, overridden through the top level parameters
  localparam int default_addr_bits = 2; // 4 words per lane
  localparam int default_data_bits = 8; // one byte from the switches
  localparam int default_num_lanes = 4; // lanes picked by lane_sel

  // width of lane_sel and read_lane, kept at least one bit wide
  localparam int lane_index_bits =
    (default_num_lanes > 1) ? $clog2(default_num_lanes) : 1;

endpackage

// ==== design/command_decoder.sv ====
`timescale 1ns/10ps

module command_decoder
  import fifo_bank_pkg::*;
#(
  parameter int num_lanes = default_num_lanes
)
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       wr_button,   // level from write push-button
  input  logic                       rd_button,   // level from read push-button
  input  logic [lane_index_bits-1:0] lane_sel,    // sampled with the buttons
  output lane_op_t                   lane_op [num_lanes],
  output logic [lane_index_bits-1:0] read_lane,   // lane of the last read press
  output logic                       read_strobe  // one cycle per read press
);

  logic     wr_prev;           // button level at the previous edge
  logic     rd_prev;
  logic     wr_rise;           // high only on the first sampled-high edge
  logic     rd_rise;
  lane_op_t rise_op;           // decoded operation for this edge
  logic [num_lanes-1:0] lane_busy; // non-idle lanes, for the check below

  assign wr_rise = wr_button & ~wr_prev; // held button gives one rise only
  assign rd_rise = rd_button & ~rd_prev;

  always_comb
  begin
    case ({wr_rise, rd_rise})
      2'b11:   rise_op = op_both;  // both rose at the same edge
      2'b10:   rise_op = op_write; // a held read does not count again
      2'b01:   rise_op = op_read;
      default: rise_op = op_idle;
    endcase
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_prev     <= 1'b0;
      rd_prev     <= 1'b0;
      read_lane   <= '0;
      read_strobe <= 1'b0;
      for (int i = 0; i < num_lanes; i++)
        lane_op[i] <= op_idle;
    end
    else
    begin
      wr_prev     <= wr_button;
      rd_prev     <= rd_button;
      read_strobe <= rd_rise;      // registered, so lines up with lane_op
      if (rd_rise)
        read_lane <= lane_sel;     // held until the next read press
      for (int i = 0; i < num_lanes; i++)
      begin
        // only the selected lane sees the operation, the rest stay idle
        if (lane_sel == lane_index_bits'(i))
          lane_op[i] <= rise_op;
        else
          lane_op[i] <= op_idle;
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < num_lanes; i++)
      lane_busy[i] = (lane_op[i] != op_idle);
  end

  // a single lane is addressed per press
  a_one_lane_busy: assert property (@(posedge clock) disable iff (reset)
    $onehot0(lane_busy));

endmodule

// ==== design/fifo_lane.sv ====
`timescale 1ns/10ps

module fifo_lane
  import fifo_bank_pkg::*;
#(
  parameter int addr_bits = default_addr_bits,
  parameter int data_bits = default_data_bits
)
(
  input  logic                 clock,
  input  logic                 reset,
  input  lane_op_t             op,        // one-cycle strobe from the decoder
  input  logic [data_bits-1:0] din,       // switch value, stored on a write
  output logic [data_bits-1:0] lane_data, // word from the last real pop
  output logic                 pop_done,  // one cycle after a real read
  output logic                 empty,
  output logic                 full
);

  localparam int depth = 2 ** addr_bits; // words held per lane

  logic [data_bits-1:0] mem [depth];     // word storage
  logic [addr_bits-1:0] wr_ptr;          // next slot to write
  logic [addr_bits-1:0] rd_ptr;          // oldest stored word
  logic [addr_bits-1:0] wr_succ;         // pointer after this write
  logic [addr_bits-1:0] rd_succ;         // pointer after this read
  logic                 do_write;        // write that really happens
  logic                 do_read;         // read that really happens

  assign wr_succ = wr_ptr + 1'b1;        // wraps at depth
  assign rd_succ = rd_ptr + 1'b1;

  // a full lane still accepts op_both since the pop frees the slot
  assign do_write = op[1] & (~full | op[0]);
  // empty lane drops the read, op_both there becomes write only
  assign do_read  = op[0] & ~empty;

  // storage and read port
  always_ff @(posedge clock)
  begin
    if (do_write)
      mem[wr_ptr] <= din;
    if (do_read)
      lane_data <= mem[rd_ptr];          // old word, even when wr_ptr == rd_ptr
  end

  // pointers and flags
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      empty    <= 1'b1;                  // lane starts empty
      full     <= 1'b0;
      pop_done <= 1'b0;
    end
    else
    begin
      pop_done <= do_read;
      if (do_write)
        wr_ptr <= wr_succ;
      if (do_read)
        rd_ptr <= rd_succ;
      case ({do_write, do_read})
        2'b10:                           // push only
        begin
          empty <= 1'b0;
          if (wr_succ == rd_ptr)
            full <= 1'b1;                // writer caught up with reader
        end
        2'b01:                           // pop only
        begin
          full <= 1'b0;
          if (rd_succ == wr_ptr)
            empty <= 1'b1;               // last word taken
        end
        default:
        begin
          // idle, or push and pop together with the count unchanged
          empty <= empty;
          full  <= full;
        end
      endcase
    end
  end

  a_flags_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(full && empty));

  // equal pointers without full mean no word is stored, so no pop may follow
  a_no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
    (op[0] && (rd_ptr == wr_ptr) && !full) |=> !pop_done);

endmodule

// ==== design/read_collector.sv ====
`timescale 1ns/10ps

module read_collector
  import fifo_bank_pkg::*;
#(
  parameter int data_bits = default_data_bits,
  parameter int num_lanes = default_num_lanes
)
(
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic [lane_index_bits-1:0]           read_lane,     // from the decoder
  input  logic [num_lanes-1:0][data_bits-1:0]  lane_data_all, // read port of every lane
  input  logic [num_lanes-1:0]                 pop_done_all,
  input  logic [num_lanes-1:0]                 empty_all,
  input  logic [num_lanes-1:0]                 full_all,
  output logic [data_bits-1:0]                 data_out,      // held until next pop
  output logic [num_lanes-1:0]                 empty_flags,
  output logic [num_lanes-1:0]                 full_flags,
  output logic                                 any_full,      // alarm lamp
  output logic                                 ready_led      // lit once out of reset
);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      data_out    <= '0;
      empty_flags <= '1;                 // all lanes empty after reset
      full_flags  <= '0;
      any_full    <= 1'b0;
      ready_led   <= 1'b0;
    end
    else
    begin
      // read_lane is still valid here, a new read press cannot land earlier
      if (pop_done_all[read_lane])
        data_out <= lane_data_all[read_lane];
      empty_flags <= empty_all;
      full_flags  <= full_all;
      any_full    <= |full_all;          // any lane full lights the alarm
      ready_led   <= 1'b1;
    end
  end

  a_single_pop: assert property (@(posedge clock) disable iff (reset)
    $onehot0(pop_done_all));

  // the lane that popped is the one the decoder recorded for the read
  a_pop_from_read_lane: assert property (@(posedge clock) disable iff (reset)
    (|pop_done_all) |-> pop_done_all[read_lane]);

endmodule

// ==== design/button_fifo_bank.sv ====
`timescale 1ns/10ps

module button_fifo_bank
  import fifo_bank_pkg::*;
#(
  parameter int addr_bits = default_addr_bits,
  parameter int data_bits = default_data_bits,
  parameter int num_lanes = default_num_lanes
)
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       wr_button,
  input  logic                       rd_button,
  input  logic [lane_index_bits-1:0] lane_sel,
  input  logic [data_bits-1:0]       din,
  output logic [data_bits-1:0]       data_out,
  output logic [num_lanes-1:0]       empty_flags,
  output logic [num_lanes-1:0]       full_flags,
  output logic                       any_full,
  output logic                       ready_led
);

  lane_op_t                           lane_op [num_lanes]; // per-lane strobes
  logic [lane_index_bits-1:0]         read_lane;
  logic [num_lanes-1:0][data_bits-1:0] lane_data_all;      // read ports, lane order
  logic [num_lanes-1:0]               pop_done_all;
  logic [num_lanes-1:0]               empty_all;
  logic [num_lanes-1:0]               full_all;

  command_decoder #(
    .num_lanes   (num_lanes)
  ) i_decoder (
    .clock       (clock),
    .reset       (reset),
    .wr_button   (wr_button),
    .rd_button   (rd_button),
    .lane_sel    (lane_sel),
    .lane_op     (lane_op),
    .read_lane   (read_lane),
    .read_strobe ()            // collector keys on pop_done instead
  );

  for (genvar i = 0; i < num_lanes; i++)
  begin : g_lane
    fifo_lane #(
      .addr_bits (addr_bits),
      .data_bits (data_bits)
    ) i_lane (
      .clock     (clock),
      .reset     (reset),
      .op        (lane_op[i]),
      .din       (din),        // shared, only the strobed lane stores it
      .lane_data (lane_data_all[i]),
      .pop_done  (pop_done_all[i]),
      .empty     (empty_all[i]),
      .full      (full_all[i])
    );
  end

  read_collector #(
    .data_bits     (data_bits),
    .num_lanes     (num_lanes)
  ) i_collector (
    .clock         (clock),
    .reset         (reset),
    .read_lane     (read_lane),
    .lane_data_all (lane_data_all),
    .pop_done_all  (pop_done_all),
    .empty_all     (empty_all),
    .full_all      (full_all),
    .data_out      (data_out),
    .empty_flags   (empty_flags),
    .full_flags    (full_flags),
    .any_full      (any_full),
    .ready_led     (ready_led)
  );

endmodule

// ==== test/button_fifo_bank_tb.sv ====
`timescale 1ns/10ps

module button_fifo_bank_tb
  import fifo_bank_pkg::*;
();

  localparam int addr_bits     = default_addr_bits;
  localparam int data_bits     = default_data_bits;
  localparam int num_lanes     = default_num_lanes;
  localparam int depth         = 1 << addr_bits;  // words per lane
  localparam int ready_timeout = 20;              // cycles allowed for the lamp

  // button patterns as {write, read}
  localparam logic [1:0] btn_none  = 2'b00;       // release, nothing pressed
  localparam logic [1:0] btn_read  = 2'b01;
  localparam logic [1:0] btn_write = 2'b10;
  localparam logic [1:0] btn_both  = 2'b11;

  logic                       clock;
  logic                       reset;
  logic                       wr_button;
  logic                       rd_button;
  logic [lane_index_bits-1:0] lane_sel;
  logic [data_bits-1:0]       din;
  logic [data_bits-1:0]       data_out;
  logic [num_lanes-1:0]       empty_flags;
  logic [num_lanes-1:0]       full_flags;
  logic                       any_full;
  logic                       ready_led;

  logic [data_bits-1:0] model_q [num_lanes][$]; // reference contents per lane
  logic [data_bits-1:0] exp_data;               // last word popped in the model
  int                   error_count;
  int                   test_errors;            // errors in the running test
  int                   failed_tests;
  int                   tab_test [$];           // stimulus table, one row per press
  int                   tab_lane [$];
  logic [1:0]           tab_btn  [$];
  int                   tab_hold [$];           // cycles the button stays down
  string                test_name [6] = '{"reset state", "write then read in order",
    "fill and overflow", "empty read and long hold", "independent lanes",
    "combined read-write"};

  button_fifo_bank #(
    .addr_bits   (addr_bits),
    .data_bits   (data_bits),
    .num_lanes   (num_lanes)
  ) i_dut (
    .clock       (clock),
    .reset       (reset),
    .wr_button   (wr_button),
    .rd_button   (rd_button),
    .lane_sel    (lane_sel),
    .din         (din),
    .data_out    (data_out),
    .empty_flags (empty_flags),
    .full_flags  (full_flags),
    .any_full    (any_full),
    .ready_led   (ready_led)
  );

  always #2 clock = ~clock; // 4 ns period

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, expected);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic add_entry(input int test, input int lane, input logic [1:0] btn,
                           input int hold);
    tab_test.push_back(test);
    tab_lane.push_back(lane);
    tab_btn.push_back(btn);
    tab_hold.push_back(hold);
  endtask

  task automatic build_table();
    add_entry(1, 0, btn_none, 3);                       // no press, state stays
    repeat (3) add_entry(2, 1, btn_write, 3);
    repeat (3) add_entry(2, 1, btn_read, 3);            // last one empties lane 1
    repeat (5) add_entry(3, 2, btn_write, 3);           // fifth write hits a full lane
    repeat (4) add_entry(3, 2, btn_read, 3);
    add_entry(4, 0, btn_read, 10);                      // empty lane, data_out holds
    add_entry(4, 0, btn_write, 12);                     // long hold, one push only
    add_entry(4, 0, btn_read, 8);
    add_entry(4, 0, btn_read, 3);                       // empty again
    add_entry(5, 0, btn_write, 3);
    add_entry(5, 3, btn_write, 3);
    add_entry(5, 0, btn_write, 3);
    add_entry(5, 3, btn_write, 3);
    add_entry(5, 3, btn_read, 3);
    add_entry(5, 0, btn_read, 3);
    add_entry(5, 3, btn_read, 3);
    add_entry(5, 0, btn_read, 3);
    repeat (2) add_entry(6, 1, btn_write, 3);
    add_entry(6, 1, btn_both, 3);                       // pop oldest, push new
    repeat (2) add_entry(6, 1, btn_read, 3);
    add_entry(6, 1, btn_both, 3);                       // empty lane, push only
    add_entry(6, 1, btn_read, 3);
  endtask

  // lane rule applied to the reference queues
  task automatic model_step(input int lane, input logic [1:0] btn,
                            input logic [data_bits-1:0] word);
    case (btn)
      btn_write:
        if (model_q[lane].size() < depth)
          model_q[lane].push_back(word);
      btn_read:
        if (model_q[lane].size() > 0)
          exp_data = model_q[lane].pop_front();
      btn_both:
      begin
        if (model_q[lane].size() > 0)
          exp_data = model_q[lane].pop_front();        // full lane frees a slot first
        model_q[lane].push_back(word);
      end
      default: ;
    endcase
  endtask

  task automatic check_outputs();
    logic [num_lanes-1:0] exp_empty;
    logic [num_lanes-1:0] exp_full;
    for (int l = 0; l < num_lanes; l++)
    begin
      exp_empty[l] = (model_q[l].size() == 0);
      exp_full[l]  = (model_q[l].size() == depth);
    end
    check_value("data_out", 32'(data_out), 32'(exp_data));
    check_value("empty_flags", 32'(empty_flags), 32'(exp_empty));
    check_value("full_flags", 32'(full_flags), 32'(exp_full));
    check_value("any_full", 32'(any_full), 32'(|exp_full));
    check_value("ready_led", 32'(ready_led), 32'd1);
  endtask

  task automatic apply_entry(input int idx);
    logic [data_bits-1:0] word;
    word = data_bits'($urandom());
    @(posedge clock);
    wr_button <= tab_btn[idx][1];
    rd_button <= tab_btn[idx][0];
    lane_sel  <= lane_index_bits'(tab_lane[idx]);
    din       <= word;
    model_step(tab_lane[idx], tab_btn[idx], word);
    repeat (3) @(posedge clock);                      // edge 0 samples the rise, outputs at edge 2
    @(negedge clock);
    check_outputs();
    if (tab_hold[idx] > 3)
    begin
      repeat (tab_hold[idx] - 3) @(posedge clock);    // keep holding, nothing may change
      @(negedge clock);
      check_outputs();
    end
    @(posedge clock);
    wr_button <= 1'b0;
    rd_button <= 1'b0;
    @(posedge clock);                                 // decoder sees the release
  endtask

  task automatic wait_ready(output logic seen);
    int cycles;
    cycles = 0;
    while (!ready_led && cycles < ready_timeout)
    begin
      @(negedge clock);
      cycles++;
    end
    seen = ready_led;
  endtask

  initial
  begin
    logic ready_ok;
    void'($urandom(69));
    clock        = 1'b0;
    reset        = 1'b1;
    wr_button    = 1'b0;
    rd_button    = 1'b0;
    lane_sel     = '0;
    din          = '0;
    exp_data     = '0;
    error_count  = 0;
    test_errors  = 0;
    failed_tests = 0;
    build_table();
    repeat (3) @(posedge clock);
    @(negedge clock);
    check_value("ready_led in reset", 32'(ready_led), 32'd0);
    @(posedge clock);
    reset <= 1'b0;
    wait_ready(ready_ok);
    if (!ready_ok)
    begin
      $display("ready_led did not light within %0d cycles after reset", ready_timeout);
      $display("FAIL: see errors above");
      $finish;
    end
    else
    begin
      check_outputs();                                // reset values before any press
      for (int t = 1; t <= 6; t++)
      begin
        for (int i = 0; i < tab_test.size(); i++)
          if (tab_test[i] == t)
            apply_entry(i);
        $display("test %0d %s: %s", t, test_name[t-1], (test_errors == 0) ? "ok" : "failed");
        if (test_errors != 0)
          failed_tests++;
        test_errors = 0;
      end
      $display("6 tests run, %0d failed, %0d errors", failed_tests, error_count);
      if (error_count == 0)
        $display("PASS: all tests");
      else
        $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule

// ==== button_fifo_bank.f ====
design/fifo_bank_pkg.sv
design/command_decoder.sv
design/fifo_lane.sv
design/read_collector.sv
design/button_fifo_bank.sv
test/button_fifo_bank_tb.sv

// ==== Makefile ====
# Verilator build and run of the push-button FIFO bank testbench

VERILATOR ?= verilator
TOP       ?= button_fifo_bank_tb
FILELIST  ?= button_fifo_bank.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_TEXT ?= FAIL: see errors above
PASS_TEXT ?= PASS: all tests

SIM = $(BUILD_DIR)/V$(TOP)
SRC = $(wildcard design/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRC)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
